// ==== common/head_load_if.sv ====
`timescale 1ns/100ps

// head register load bus, controller to the per-vc head registers
interface head_load_if import noc_pkg::*; ();

    vc_onehot_t load;           // bypass load strobe per vc
    head_flit_t load_flit;      // bypass flit, shared by all vcs
    class_t     load_class;     // class of bypass flit
    vc_onehot_t refill;         // ram refill strobe per vc
    head_flit_t refill_flit;    // ram readout flit
    class_t     refill_class;   // class of ram readout flit
    vc_onehot_t arm;            // vc gains a flit this cycle
    vc_onehot_t pop;            // head consumed, nothing behind it

    modport ctrl (
        output load, load_flit, load_class,
        output refill, refill_flit, refill_class,
        output arm, pop
    );

    modport head (
        input load, load_flit, load_class,
        input refill, refill_flit, refill_class,
        input arm, pop
    );

    // read side only watches the valid updates
    modport status (
        input arm, pop
    );

endinterface

// ==== common/noc_pkg.sv ====
package noc_pkg;

    localparam int V    = 4;                        // virtual channels
    localparam int FPAY = 32;                       // payload bits
    localparam int C    = 2;                        // traffic classes

    localparam int VW = (V > 1) ? $clog2(V) : 1;    // binary vc index width
    localparam int CW = (C > 1) ? $clog2(C) : 1;    // class number width
    localparam int FW = 2 + V + FPAY;               // hdr, tail, vc tag, payload
    localparam int HW = 2 + FPAY;                   // stored head, tag dropped

    // flag positions
    localparam int FLIT_HDR  = FW - 1;
    localparam int FLIT_TAIL = FW - 2;
    localparam int HEAD_HDR  = HW - 1;
    localparam int HEAD_TAIL = HW - 2;

    localparam int CLASS_LSB = 24;                  // class field in header payload

    typedef logic [V-1:0]    vc_onehot_t;
    typedef logic [VW-1:0]   vc_bin_t;
    typedef logic [FPAY-1:0] payload_t;
    typedef logic [CW-1:0]   class_t;
    typedef logic [FW-1:0]   flit_t;
    typedef logic [HW-1:0]   head_flit_t;

    // one-hot vc select to binary index
    function automatic vc_bin_t onehot_to_bin(input vc_onehot_t oh);
        vc_bin_t idx;
        idx = '0;
        for (int i = 0; i < V; i++) begin
            if (oh[i]) begin
                idx = idx | vc_bin_t'(i);   // or-reduce, exact for one-hot
            end
        end
        return idx;
    endfunction

    // drop the vc tag, keep flags and payload
    function automatic head_flit_t to_head(input flit_t f);
        return {f[FLIT_HDR], f[FLIT_TAIL], f[FPAY-1:0]};
    endfunction

endpackage

// ==== flit_buffer/vc_head_reg.sv ====
`timescale 1ns/100ps

module vc_head_reg import noc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    head_load_if.head  hl,
    input  vc_bin_t    vc_idx_i,            // own position in the vc vectors
    output head_flit_t head_o,
    output class_t     class_o,
    output logic       valid_o
);

    head_flit_t head_q;                     // oldest flit of this vc
    class_t     class_q;                    // class of packet at head
    logic       valid_q;
    logic       ld, rf, arm, pop;

    assign ld  = hl.load[vc_idx_i];         // bypass load
    assign rf  = hl.refill[vc_idx_i];       // refill from ram
    assign arm = hl.arm[vc_idx_i];
    assign pop = hl.pop[vc_idx_i];

    // arm wins over pop
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (arm) begin
            valid_q <= 1'b1;
        end else if (pop) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ld) begin
            head_q <= hl.load_flit;
        end else if (rf) begin
            head_q <= hl.refill_flit;
        end
    end

    // body flits leave the class alone
    always_ff @(posedge clk) begin
        if (reset) begin
            class_q <= '0;
        end else if (ld && hl.load_flit[HEAD_HDR]) begin
            class_q <= hl.load_class;
        end else if (rf && hl.refill_flit[HEAD_HDR]) begin
            class_q <= hl.refill_class;
        end
    end

    assign head_o  = head_q;
    assign class_o = class_q;
    assign valid_o = valid_q;

    // a load lands one cycle after the arm that announced it
    a_load_armed : assert property (@(posedge clk) disable iff (reset)
        (ld || rf) |-> (valid_q || $past(arm)))
        else $error("head %0d loaded without arm", vc_idx_i);

    a_one_source : assert property (@(posedge clk) disable iff (reset)
        !(ld && rf))
        else $error("head %0d bypass and refill together", vc_idx_i);

endmodule

// ==== flit_buffer/vc_ram_fifo.sv ====
`timescale 1ns/100ps

module vc_ram_fifo import noc_pkg::*; #(
    parameter int B = 4                         // flits per vc
) (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      din_i,
    input  logic       wr_en_i,
    input  vc_onehot_t wr_vc_i,
    input  logic       rd_en_i,
    input  vc_onehot_t rd_vc_i,
    output flit_t      dout_o,
    output vc_onehot_t not_empty_o
);

    localparam int PTRW  = (B > 1) ? $clog2(B) : 1;
    localparam int CNTW  = $clog2(B + 1);
    localparam int DEPTH = V * B;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    flit_t mem [DEPTH];                         // one slice of B per vc
    flit_t dout_q;                              // registered read port

    logic [PTRW-1:0] wr_ptr [V];
    logic [PTRW-1:0] rd_ptr [V];
    logic [CNTW-1:0] cnt    [V];

    vc_onehot_t wr_sel, rd_sel;
    vc_bin_t    wr_bin, rd_bin;
    logic [AW-1:0] wr_addr, rd_addr;

    // pointer wrap inside a slice
    function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
        return (p == PTRW'(B - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_sel = wr_en_i ? wr_vc_i : '0;     // masked selects
    assign rd_sel = rd_en_i ? rd_vc_i : '0;
    assign wr_bin = onehot_to_bin(wr_vc_i);
    assign rd_bin = onehot_to_bin(rd_vc_i);

    assign wr_addr = AW'(int'(wr_bin) * B + int'(wr_ptr[wr_bin]));  // slice base + ptr
    assign rd_addr = AW'(int'(rd_bin) * B + int'(rd_ptr[rd_bin]));

    // per-vc pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < V; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < V; i++) begin
                if (wr_sel[i]) begin
                    wr_ptr[i] <= ptr_inc(wr_ptr[i]);
                end
                if (rd_sel[i]) begin
                    rd_ptr[i] <= ptr_inc(rd_ptr[i]);
                end
                cnt[i] <= cnt[i] + CNTW'(wr_sel[i]) - CNTW'(rd_sel[i]);  // both may hit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr] <= din_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            dout_q <= mem[rd_addr];             // data one cycle after rd_en_i
        end
    end

    assign dout_o = dout_q;

    generate
        for (genvar g = 0; g < V; g++) begin : g_status
            assign not_empty_o[g] = (cnt[g] != '0);
        end
    endgenerate

    // upstream credits must keep slices within B
    a_no_overflow : assert property (@(posedge clk) disable iff (reset)
        wr_en_i |-> (cnt[wr_bin] != CNTW'(B)))
        else $error("ram fifo write to full vc %0d", wr_bin);

    a_no_underflow : assert property (@(posedge clk) disable iff (reset)
        rd_en_i |-> (cnt[rd_bin] != '0))
        else $error("ram fifo read from empty vc %0d", rd_bin);

endmodule

// ==== hdl/bypass_ctrl.sv ====
`timescale 1ns/100ps

module bypass_ctrl import noc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      din_i,
    input  logic       wr_en_i,
    input  vc_onehot_t wr_vc_i,
    input  logic       rd_en_i,
    input  vc_onehot_t rd_vc_i,
    input  vc_onehot_t head_valid_i,        // per-vc head state
    input  vc_onehot_t ram_not_empty_i,
    input  flit_t      ram_dout_i,          // registered ram readout
    output logic       ram_wr_o,
    output logic       ram_rd_o,
    head_load_if.ctrl  hl
);

    vc_onehot_t wr_sel, rd_sel;
    vc_onehot_t ram_empty;
    vc_onehot_t bypass;                     // flit goes straight to head
    vc_onehot_t ram_rd_sel;                 // read vc has ram content
    vc_onehot_t byp_q, refill_q;            // delayed load strobes
    flit_t      din_q;                      // arriving flit, one cycle late
    payload_t   din_pay, ram_pay;

    assign wr_sel    = wr_en_i ? wr_vc_i : '0;
    assign rd_sel    = rd_en_i ? rd_vc_i : '0;
    assign ram_empty = ~ram_not_empty_i;

    // head free, or head leaving with nothing behind it
    assign bypass     = wr_sel & (~head_valid_i | (rd_sel & ram_empty));
    assign ram_rd_sel = rd_sel & ram_not_empty_i;

    assign ram_wr_o = wr_en_i & ~(|bypass);   // everything else queues in ram
    assign ram_rd_o = |ram_rd_sel;

    assign hl.arm = bypass | ram_rd_sel;      // head valid from next cycle
    assign hl.pop = rd_sel & ram_empty;       // overridden by arm on bypass

    always_ff @(posedge clk) begin
        if (reset) begin
            byp_q    <= '0;
            refill_q <= '0;
        end else begin
            byp_q    <= bypass;
            refill_q <= ram_rd_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            din_q <= din_i;
        end
    end

    assign din_pay = din_q[FPAY-1:0];
    assign ram_pay = ram_dout_i[FPAY-1:0];

    // bypass path
    assign hl.load       = byp_q;
    assign hl.load_flit  = to_head(din_q);
    assign hl.load_class = din_q[FLIT_HDR] ? din_pay[CLASS_LSB +: CW] : '0;

    // refill path, ram data valid with refill_q
    assign hl.refill       = refill_q;
    assign hl.refill_flit  = to_head(ram_dout_i);
    assign hl.refill_class = ram_dout_i[FLIT_HDR] ? ram_pay[CLASS_LSB +: CW] : '0;

    a_wr_onehot : assert property (@(posedge clk) disable iff (reset)
        wr_en_i |-> $onehot(wr_vc_i))
        else $error("write vc select not one-hot: %h", wr_vc_i);

    a_rd_onehot : assert property (@(posedge clk) disable iff (reset)
        rd_en_i |-> $onehot(rd_vc_i))
        else $error("read vc select not one-hot: %h", rd_vc_i);

endmodule

// ==== hdl/input_port_top.sv ====
`timescale 1ns/100ps

module input_port_top import noc_pkg::*; #(
    parameter int B = 4                     // ram flits per vc
) (
    input  logic            clk,
    input  logic            reset,
    input  flit_t           din_i,
    input  logic            wr_en_i,
    input  vc_onehot_t      wr_vc_i,
    input  logic            rd_en_i,
    input  vc_onehot_t      rd_vc_i,
    output flit_t           dout_o,
    output vc_onehot_t      vc_not_empty_o,
    output logic [V*CW-1:0] class_all_o
);

    logic       ram_wr, ram_rd;
    flit_t      ram_dout;
    vc_onehot_t ram_not_empty;
    vc_onehot_t head_valid;
    head_flit_t head_flits [V];
    class_t     classes    [V];

    head_load_if hl ();

    bypass_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .din_i           (din_i),
        .wr_en_i         (wr_en_i),
        .wr_vc_i         (wr_vc_i),
        .rd_en_i         (rd_en_i),
        .rd_vc_i         (rd_vc_i),
        .head_valid_i    (head_valid),
        .ram_not_empty_i (ram_not_empty),
        .ram_dout_i      (ram_dout),
        .ram_wr_o        (ram_wr),
        .ram_rd_o        (ram_rd),
        .hl              (hl.ctrl)
    );

    vc_ram_fifo #(.B(B)) u_ram (
        .clk         (clk),
        .reset       (reset),
        .din_i       (din_i),
        .wr_en_i     (ram_wr),
        .wr_vc_i     (wr_vc_i),
        .rd_en_i     (ram_rd),
        .rd_vc_i     (rd_vc_i),
        .dout_o      (ram_dout),
        .not_empty_o (ram_not_empty)
    );

    generate
        for (genvar g = 0; g < V; g++) begin : g_head
            vc_head_reg u_head (
                .clk      (clk),
                .reset    (reset),
                .hl       (hl.head),
                .vc_idx_i (vc_bin_t'(g)),
                .head_o   (head_flits[g]),
                .class_o  (classes[g]),
                .valid_o  (head_valid[g])
            );
        end
    endgenerate

    vc_read_mux u_mux (
        .clk            (clk),
        .reset          (reset),
        .rd_en_i        (rd_en_i),
        .rd_vc_i        (rd_vc_i),
        .head_flits_i   (head_flits),
        .classes_i      (classes),
        .valids_i       (head_valid),
        .st             (hl.status),
        .dout_o         (dout_o),
        .vc_not_empty_o (vc_not_empty_o),
        .class_all_o    (class_all_o)
    );

endmodule

// ==== hdl/vc_read_mux.sv ====
`timescale 1ns/100ps

module vc_read_mux import noc_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_en_i,
    input  vc_onehot_t        rd_vc_i,
    input  head_flit_t        head_flits_i [V],
    input  class_t            classes_i [V],
    input  vc_onehot_t        valids_i,
    head_load_if.status       st,
    output flit_t             dout_o,
    output vc_onehot_t        vc_not_empty_o,
    output logic [V*CW-1:0]   class_all_o
);

    vc_bin_t    rd_bin_q;                   // vc read last cycle
    vc_onehot_t tag;                        // rebuilt vc tag
    head_flit_t sel_head;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bin_q <= '0;
        end else if (rd_en_i) begin
            rd_bin_q <= onehot_to_bin(rd_vc_i);
        end
    end

    // head still holds the popped flit, refill lands at the next edge
    assign sel_head = head_flits_i[rd_bin_q];
    assign tag      = vc_onehot_t'(1) << rd_bin_q;
    assign dout_o   = {sel_head[HEAD_HDR], sel_head[HEAD_TAIL], tag, sel_head[FPAY-1:0]};

    assign vc_not_empty_o = valids_i;

    generate
        for (genvar g = 0; g < V; g++) begin : g_class
            assign class_all_o[g*CW +: CW] = classes_i[g];
        end
    endgenerate

    a_rd_valid : assert property (@(posedge clk) disable iff (reset)
        rd_en_i |-> |(rd_vc_i & valids_i))
        else $error("read of empty vc %h", rd_vc_i);

endmodule

// ==== list.f ====
common/noc_pkg.sv
common/head_load_if.sv
flit_buffer/vc_ram_fifo.sv
flit_buffer/vc_head_reg.sv
hdl/bypass_ctrl.sv
hdl/vc_read_mux.sv
hdl/input_port_top.sv
verification/tb_input_port.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_input_port -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// ==== verification/tb_input_port.sv ====
`timescale 1ns/100ps

module tb_input_port import noc_pkg::*; ();

    localparam int B          = 4;              // ram flits per vc
    localparam int WAIT_LIMIT = 20;             // cycles before a wait gives up
    localparam int RAND_STEPS = 200;

    logic            clk;
    logic            reset;
    flit_t           din_i;
    logic            wr_en_i;
    vc_onehot_t      wr_vc_i;
    logic            rd_en_i;
    vc_onehot_t      rd_vc_i;
    flit_t           dout_o;
    vc_onehot_t      vc_not_empty_o;
    logic [V*CW-1:0] class_all_o;

    flit_t       sb_q [V][$];                   // expected flits per vc, oldest first
    logic        pend_valid;                    // a read was issued last step
    flit_t       pend_flit;                     // what that read must return
    logic [31:0] rng_state;
    int          mismatch_count;
    int          fail_count;

    input_port_top #(.B(B)) dut (
        .clk            (clk),
        .reset          (reset),
        .din_i          (din_i),
        .wr_en_i        (wr_en_i),
        .wr_vc_i        (wr_vc_i),
        .rd_en_i        (rd_en_i),
        .rd_vc_i        (rd_vc_i),
        .dout_o         (dout_o),
        .vc_not_empty_o (vc_not_empty_o),
        .class_all_o    (class_all_o)
    );

    always #20 clk = ~clk;                      // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic vc_onehot_t vc_mask(input int vc);
        vc_onehot_t oh;
        oh     = '0;
        oh[vc] = 1'b1;
        return oh;
    endfunction

    // header flag, tail flag, one-hot tag, payload
    function automatic flit_t make_flit(input logic hdr, input logic tail, input int vc,
                                        input payload_t pay);
        flit_t f;
        f = {hdr, tail, vc_mask(vc), pay};
        return f;
    endfunction

    function automatic vc_onehot_t model_mask();
        vc_onehot_t m;
        m = '0;
        for (int v = 0; v < V; v++) begin
            m[v] = (sb_q[v].size() > 0);        // vc holds at least one flit
        end
        return m;
    endfunction

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_vc(input string name, input vc_onehot_t got, input vc_onehot_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_class(input int vc, input class_t exp);
        class_t got;
        got = class_t'(class_all_o[vc*CW +: CW]);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch class_all_o[%0d]: got %h expected %h", vc, got, exp);
        end
    endtask

    // one clock: drive at the edge, check last read's data at the falling edge
    task automatic step(input logic wr, input int wvc, input flit_t wflit,
                        input logic rd, input int rvc);
        flit_t rd_exp;
        logic  rd_has;
        rd_exp = '0;
        rd_has = 1'b0;
        @(posedge clk);
        wr_en_i <= wr;
        wr_vc_i <= wr ? vc_mask(wvc) : '0;
        din_i   <= wflit;
        rd_en_i <= rd;
        rd_vc_i <= rd ? vc_mask(rvc) : '0;
        if (rd) begin
            if (sb_q[rvc].size() == 0) begin
                fail_count++;
                $display("read of vc %0d issued with no flit expected there", rvc);
            end else begin
                rd_exp = sb_q[rvc].pop_front();   // pop before push, same-cycle case
                rd_has = 1'b1;
            end
        end
        if (wr) begin
            sb_q[wvc].push_back(wflit);
        end
        @(negedge clk);
        if (pend_valid) begin
            check_flit("dout_o", dout_o, pend_flit);
        end
        pend_valid = rd_has;
        pend_flit  = rd_exp;
    endtask

    task automatic idle();
        step(1'b0, 0, '0, 1'b0, 0);
    endtask

    task automatic write_flit(input int vc, input flit_t f);
        step(1'b1, vc, f, 1'b0, 0);
    endtask

    task automatic read_vc(input int vc);
        step(1'b0, 0, '0, 1'b1, vc);
    endtask

    // poll one not-empty bit, inputs must be idle
    task automatic wait_vc_bit(input int vc, input logic val);
        int n;
        n = 0;
        while (vc_not_empty_o[vc] !== val && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (vc_not_empty_o[vc] !== val) begin
            fail_count++;
            $display("timeout: vc %0d not-empty never became %0d", vc, val);
        end
    endtask

    task automatic reset_test();
        idle();
        check_vc("vc_not_empty_o", vc_not_empty_o, '0);
        for (int v = 0; v < V; v++) begin
            check_class(v, '0);
        end
    endtask

    task automatic bypass_test();
        vc_onehot_t exp_ne;
        exp_ne = '0;
        for (int v = 0; v < V; v++) begin
            write_flit(v, make_flit(1'b1, 1'b1, v, next_rand()));
            check_vc("vc_not_empty_o", vc_not_empty_o, exp_ne);   // not sampled yet
            exp_ne[v] = 1'b1;
        end
        idle();
        check_vc("vc_not_empty_o", vc_not_empty_o, exp_ne);
        idle();
        for (int v = 0; v < V; v++) begin
            read_vc(v);
        end
        idle();                                 // checks the last read
        check_vc("vc_not_empty_o", vc_not_empty_o, '0);
    endtask

    task automatic deep_fill_test(input int vc);
        for (int i = 0; i <= B; i++) begin
            write_flit(vc, make_flit(i == 0, i == B, vc, next_rand()));
        end
        idle();
        wait_vc_bit(vc, 1'b1);
        for (int i = 0; i <= B; i++) begin
            read_vc(vc);                        // back to back, one flit per cycle
        end
        idle();
        check_vc("vc_not_empty_o", vc_not_empty_o, '0);
    endtask

    task automatic class_test(input int vc);
        payload_t pay;
        pay = next_rand();
        pay[CLASS_LSB +: CW] = class_t'(1);
        write_flit(vc, make_flit(1'b1, 1'b0, vc, pay));
        for (int i = 0; i < 3; i++) begin
            pay = next_rand();
            pay[CLASS_LSB +: CW] = '0;          // body bits must not leak into class
            write_flit(vc, make_flit(1'b0, i == 2, vc, pay));
        end
        pay = next_rand();
        pay[CLASS_LSB +: CW] = '0;
        write_flit(vc, make_flit(1'b1, 1'b1, vc, pay));   // class 0 packet behind
        idle();
        wait_vc_bit(vc, 1'b1);
        idle();
        idle();
        check_class(vc, class_t'(1));
        for (int i = 0; i < 4; i++) begin
            read_vc(vc);
            idle();
            idle();                             // refill has landed
            check_class(vc, (i < 3) ? class_t'(1) : class_t'(0));
        end
        read_vc(vc);
        idle();
    endtask

    task automatic simul_test(input int vc);
        write_flit(vc, make_flit(1'b1, 1'b1, vc, next_rand()));
        idle();
        wait_vc_bit(vc, 1'b1);
        idle();
        step(1'b1, vc, make_flit(1'b1, 1'b1, vc, next_rand()), 1'b1, vc);
        check_vc("vc_not_empty_o", vc_not_empty_o, vc_mask(vc));
        read_vc(vc);                            // old flit checked here
        check_vc("vc_not_empty_o", vc_not_empty_o, vc_mask(vc));   // held across the swap
        idle();                                 // new flit checked here
        check_vc("vc_not_empty_o", vc_not_empty_o, '0);
    endtask

    task automatic mixed_test();
        logic [31:0] r;
        logic        wr, rd;
        int          wvc, rvc, idx;
        vc_onehot_t  exp_ne;
        for (int s = 0; s < RAND_STEPS; s++) begin
            r   = next_rand();
            rd  = 1'b0;
            wr  = 1'b0;
            rvc = 0;
            wvc = 0;
            for (int j = 0; j < V; j++) begin
                idx = (int'(r[11:4]) + j) % V;
                if (!rd && r[0] && sb_q[idx].size() > 0) begin
                    rd  = 1'b1;
                    rvc = idx;
                end
            end
            for (int j = 0; j < V; j++) begin
                idx = (int'(r[19:12]) + j) % V;
                if (!wr && r[1] && sb_q[idx].size() < B + 1) begin   // full at B+1
                    wr  = 1'b1;
                    wvc = idx;
                end
            end
            exp_ne = model_mask();              // state the dut shows this cycle
            step(wr, wvc, make_flit(r[2], r[3], wvc, next_rand()), rd, rvc);
            check_vc("vc_not_empty_o", vc_not_empty_o, exp_ne);
        end
        idle();
        for (int v = 0; v < V; v++) begin
            while (sb_q[v].size() > 0) begin
                read_vc(v);                     // drain what is left
            end
        end
        idle();
        check_vc("vc_not_empty_o", vc_not_empty_o, '0);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        din_i          = '0;
        wr_en_i        = 1'b0;
        wr_vc_i        = '0;
        rd_en_i        = 1'b0;
        rd_vc_i        = '0;
        pend_valid     = 1'b0;
        pend_flit      = '0;
        rng_state      = 32'hd899c61a;
        mismatch_count = 0;
        fail_count     = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        reset_test();
        bypass_test();
        deep_fill_test(1);
        class_test(2);
        simul_test(3);
        mixed_test();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
